/* tb.f */
+incdir+testbench
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/alu.sv
rtl/mem_bank.sv
rtl/control_unit.sv
rtl/datapath.sv
rtl/cpu_top.sv
testbench/tb_cpu.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_cpu
FILELIST  = tb.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_model.svh */
logic [15:0] prog [64];                        // word i sits at im address i
logic [15:0] dm_init [16];                     // data preload for words 0 to 15
logic [15:0] m_dm [16];
logic [15:0] m_rf [5];                         // r, r1..r4
logic [15:0] m_ac;
logic [31:0] seed = 32'hf70e;
int          prog_len;

function logic [15:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed[31:16];                        // upper half mixes better
endfunction

function logic [15:0] make_word(input logic [5:0] op, input logic [7:0] arg);
    return {op, 2'b00, arg};                   // reg select sits in arg[2:0]
endfunction

function logic [5:0] mixed_op(input logic [3:0] k);
    case (k)
        4'd0:    return OP_LDAC;
        4'd1:    return OP_STAC;
        4'd2:    return OP_MVACR;
        4'd3:    return OP_MVRAC;
        4'd4:    return OP_ADD;
        4'd5:    return OP_SUB;
        4'd6:    return OP_MULT;
        4'd7:    return OP_SHL1;
        4'd8:    return OP_SHR1;
        4'd9:    return OP_INAC;
        4'd10:   return OP_CLAC;
        4'd11:   return OP_JPNZ;
        4'd12:   return OP_NOP;
        4'd13:   return 6'd0;                  // codes outside the set
        4'd14:   return 6'd40;
        default: return 6'd63;
    endcase
endfunction

// kind 0 moves, 1 alu, 2 countdown, 3 mixed
task build_program(input int kind);
    logic [15:0] r;
    logic [5:0]  op;
    logic [7:0]  arg;
    for (int i = 0; i < 16; i++) begin
        dm_init[i] = next_rand();
    end
    case (kind)
        0: begin
            prog_len = 24;
            for (int i = 0; i < prog_len - 1; i++) begin
                r = next_rand();
                case (r[1:0])
                    2'd0:    prog[i] = make_word(OP_LDAC, {4'h0, r[5:2]});
                    2'd1:    prog[i] = make_word(OP_STAC, {4'h0, r[5:2]});
                    2'd2:    prog[i] = make_word(OP_MVACR, 8'(r[15:8] % 8'd5));
                    default: prog[i] = make_word(OP_MVRAC, 8'(r[15:8] % 8'd5));
                endcase
            end
        end
        1: begin
            prog_len = 24;
            prog[0] = make_word(OP_LDAC, 8'd0);
            prog[1] = make_word(OP_MVACR, 8'd0);   // r gets a random operand
            prog[2] = make_word(OP_LDAC, 8'd1);
            for (int i = 3; i < prog_len - 1; i++) begin
                r = next_rand();
                case (r[2:0])
                    3'd1:    prog[i] = make_word(OP_SUB, 8'd0);
                    3'd2:    prog[i] = make_word(OP_MULT, 8'd0);
                    3'd3:    prog[i] = make_word(OP_SHL1, 8'd0);
                    3'd4:    prog[i] = make_word(OP_SHR1, 8'd0);
                    3'd5:    prog[i] = make_word(OP_INAC, 8'd0);
                    3'd6:    prog[i] = make_word(OP_CLAC, 8'd0);
                    default: prog[i] = make_word(OP_ADD, 8'd0);
                endcase
            end
        end
        2: begin
            r = next_rand();
            dm_init[0] = 16'd1 + (r % 16'd20);     // loop count
            dm_init[1] = 16'd1;
            prog_len = 7;
            prog[0] = make_word(OP_LDAC, 8'd1);
            prog[1] = make_word(OP_MVACR, 8'd0);
            prog[2] = make_word(OP_LDAC, 8'd0);
            prog[3] = make_word(OP_STAC, 8'd2);    // loop head
            prog[4] = make_word(OP_SUB, 8'd0);
            prog[5] = make_word(OP_JPNZ, 8'd3);
        end
        default: begin
            r = next_rand();
            prog_len = 16 + int'(r % 16'd49);
            for (int i = 0; i < prog_len - 1; i++) begin
                r = next_rand();
                op = mixed_op(r[3:0]);
                if (op == OP_JPNZ) begin
                    arg = 8'(i + 1 + int'(r[15:8]) % (prog_len - 1 - i));  // forward only
                end else if (op == OP_MVACR || op == OP_MVRAC) begin
                    arg = 8'(r[15:8] % 8'd5);
                end else begin
                    arg = {4'h0, r[7:4]};
                end
                prog[i] = make_word(op, arg);
            end
        end
    endcase
    prog[prog_len - 1] = make_word(OP_ENDOP, 8'd0);
endtask

task run_model();
    int          pc;
    int          steps;
    logic        halted;
    logic [15:0] w;
    logic [2:0]  rs;
    pc = 0;
    steps = 0;
    halted = 1'b0;
    m_ac = '0;
    for (int i = 0; i < 5; i++) begin
        m_rf[i] = '0;
    end
    for (int i = 0; i < 16; i++) begin
        m_dm[i] = dm_init[i];
    end
    while (!halted && steps < 2000) begin
        w = prog[pc];
        rs = (w[2:0] > 3'd4) ? 3'd0 : w[2:0];
        pc++;
        steps++;
        case (w[15:10])
            OP_LDAC:  m_ac = m_dm[w[3:0]];
            OP_STAC:  m_dm[w[3:0]] = m_ac;
            OP_MVACR: m_rf[rs] = m_ac;
            OP_MVRAC: m_ac = m_rf[rs];
            OP_ADD:   m_ac = m_ac + m_rf[0];
            OP_SUB:   m_ac = m_ac - m_rf[0];
            OP_MULT:  m_ac = m_ac * m_rf[0];     // low 16 bits kept
            OP_SHL1:  m_ac = m_ac << 1;
            OP_SHR1:  m_ac = m_ac >> 1;
            OP_INAC:  m_ac = m_ac + 16'd1;
            OP_CLAC:  m_ac = '0;
            OP_JPNZ:  if (m_ac != 16'd0) pc = int'(w[7:0]);
            OP_ENDOP: halted = 1'b1;
            default:  ;                          // nop and unknown codes
        endcase
    end
endtask

/* testbench/tb_cpu.sv */
`timescale 1ns/1ns

module tb_cpu
    import isa_pkg::*;
    import ctrl_pkg::*;
();

    localparam int CLK_NS      = 100;
    localparam int N_PROGS     = 13;           // tests 2 to 4 plus ten mixed
    localparam int WATCHDOG_NS = N_PROGS * 64 * 4 * CLK_NS * 2;
    localparam int DONE_LIMIT  = 1024;         // cycles allowed per program

    logic      clk;
    logic      rst_n;
    logic      start;
    host_req_t host_req;
    data_t     host_rdata;
    logic      done;
    data_t     acc;

    int errors      = 0;
    int checks      = 0;
    int test_errors = 0;
    int tests_run   = 0;

    `include "tb_model.svh"

    cpu_top #(
        .IM_DEPTH (256),
        .DM_DEPTH (256)
    ) dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .host_req   (host_req),
        .host_rdata (host_rdata),
        .done       (done),
        .acc        (acc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    task check_value(input string name, input logic [15:0] expected, input logic [15:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("FAILED %0t ns %s expected %h actual %h", $time, name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, test_errors);
        end
        test_errors = 0;
    endtask

    task apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // one host write per cycle, code first, then data
    task load_memories();
        @(posedge clk);
        for (int i = 0; i < prog_len; i++) begin
            host_req <= {1'b1, 1'b0, 8'(i), prog[i]};
            @(posedge clk);
        end
        for (int i = 0; i < 16; i++) begin
            host_req <= {1'b0, 1'b1, 8'(i), dm_init[i]};
            @(posedge clk);
        end
        host_req <= '0;
    endtask

    task pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task wait_done(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (done !== 1'b1 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (done !== 1'b1) begin
            $display("done never rose within %0d cycles of start", limit);
            errors++;
            test_errors++;
        end
    endtask

    task read_dm(input logic [7:0] a, output data_t v);
        @(posedge clk);
        host_req <= {1'b0, 1'b0, a, 16'h0000};
        @(negedge clk);
        v = host_rdata;                        // combinational read port
    endtask

    task compare_results();
        data_t v;
        check_value("acc", m_ac, acc);
        for (int i = 0; i < 16; i++) begin
            read_dm(8'(i), v);
            check_value($sformatf("host_rdata[%0d]", i), m_dm[i], v);
        end
    endtask

    task run_case(input int kind);
        build_program(kind);
        run_model();
        apply_reset();
        load_memories();
        pulse_start();
        wait_done(DONE_LIMIT);
        compare_results();
    endtask

    initial begin
        data_t v;
        rst_n    = 1'b0;
        start    = 1'b0;
        host_req = '0;
        apply_reset();

        repeat (20) begin
            @(negedge clk);
            check_value("done", 16'd0, {15'd0, done});
            check_value("acc", 16'd0, acc);
        end
        finish_test("idle after reset");

        run_case(0);
        finish_test("register and memory moves");

        run_case(1);
        finish_test("alu operations");

        run_case(2);
        check_value("acc", 16'd0, acc);
        read_dm(8'd2, v);
        check_value("host_rdata[2]", 16'd1, v);    // last value stored before zero
        repeat (10) begin
            @(negedge clk);
            check_value("done", 16'd1, {15'd0, done});
        end
        finish_test("countdown loop");

        repeat (10) run_case(3);
        finish_test("mixed programs");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* rtl/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top
    import isa_pkg::*;
    import ctrl_pkg::*;
#(
    parameter int IM_DEPTH = 256,
    parameter int DM_DEPTH = 256
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  host_req_t host_req,
    output data_t     host_rdata,
    output logic      done,
    output data_t     acc
);

    ctrl_word_t ctrl;
    instr_u     instr;
    logic       ac_zero;
    addr_t      pc;
    addr_t      ar;
    data_t      im_rdata;
    data_t      dm_rdata;
    data_t      dm_wdata;
    logic       dm_we;

    control_unit cu_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .instr   (instr),
        .ac_zero (ac_zero),
        .ctrl    (ctrl),
        .done    (done)
    );

    datapath dp_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .im_rdata (im_rdata),
        .dm_rdata (dm_rdata),
        .instr    (instr),
        .ac_zero  (ac_zero),
        .pc       (pc),
        .ar       (ar),
        .dm_wdata (dm_wdata),
        .dm_we    (dm_we),
        .acc      (acc)
    );

    mem_bank #(.DEPTH(IM_DEPTH)) im_i (
        .clk        (clk),
        .we         (1'b0),                    // core never writes code
        .addr       (pc),
        .wdata      ('0),
        .rdata      (im_rdata),
        .host_we    (host_req.im_we),
        .host_addr  (host_req.addr),
        .host_wdata (host_req.wdata),
        .host_rdata ()
    );

    mem_bank #(.DEPTH(DM_DEPTH)) dm_i (
        .clk        (clk),
        .we         (dm_we),
        .addr       (ar),
        .wdata      (dm_wdata),
        .rdata      (dm_rdata),
        .host_we    (host_req.dm_we),
        .host_addr  (host_req.addr),
        .host_wdata (host_req.wdata),
        .host_rdata (host_rdata)
    );

endmodule

/* rtl/datapath.sv */
`timescale 1ns/1ns

module datapath
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ctrl_word_t ctrl,
    input  data_t      im_rdata,
    input  data_t      dm_rdata,
    output instr_u     instr,
    output logic       ac_zero,
    output addr_t      pc,
    output addr_t      ar,
    output data_t      dm_wdata,
    output logic       dm_we,
    output data_t      acc
);

    addr_t      pc_q;
    addr_t      ar_q;
    instr_u     ir_q;
    data_t      ac_q;
    data_t      rf_q [5];                      // r, r1..r4
    logic [2:0] rf_idx;
    data_t      bus;
    data_t      alu_y;

    assign rf_idx = (ir_q.rg.rsel > REG_R4) ? 3'd0 : ir_q.rg.rsel;

    always_comb begin
        case (ctrl.bus_src)
            BUS_AC:      bus = ac_q;
            BUS_RSEL:    bus = rf_q[rf_idx];
            BUS_IR_ADDR: bus = {8'h00, ir_q.mem.addr};
            BUS_DM:      bus = dm_rdata;
            BUS_IM:      bus = im_rdata;
            default:     bus = '0;
        endcase
    end

    alu u_alu (
        .a  (ac_q),
        .b  (rf_q[0]),                         // alu always reads r
        .op (ctrl.alu_op),
        .y  (alu_y)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= '0;
            ac_q <= '0;
            for (int i = 0; i < 5; i++) begin
                rf_q[i] <= '0;
            end
        end else begin
            if (ctrl.pc_clr) pc_q <= '0;
            else if (ctrl.ld_pc) pc_q <= bus[7:0];
            else if (ctrl.pc_inc) pc_q <= pc_q + 8'd1;

            if (ctrl.ac_clr) ac_q <= '0;
            else if (ctrl.ac_inc) ac_q <= ac_q + 16'd1;
            else if (ctrl.ld_ac) ac_q <= ctrl.ac_from_alu ? alu_y : bus;

            if (ctrl.ld_rsel) rf_q[rf_idx] <= bus;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ld_ar) ar_q <= bus[7:0];
        if (ctrl.ld_ir) ir_q <= bus;
    end

    assign instr    = ir_q;
    assign ac_zero  = (ac_q == '0);
    assign pc       = pc_q;
    assign ar       = ar_q;
    assign dm_wdata = bus;                     // only ac drives it on a store
    assign dm_we    = ctrl.ld_dm;
    assign acc      = ac_q;

endmodule

/* rtl/control_unit.sv */
`timescale 1ns/1ns

module control_unit
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  instr_u     instr,
    input  logic       ac_zero,
    output ctrl_word_t ctrl,
    output logic       done
);

    typedef enum logic [4:0] {
        S_IDLE,
        S_FETCH1,
        S_FETCH2,
        S_LDAC1,
        S_LDAC2,
        S_STAC1,
        S_STAC2,
        S_MVACR,
        S_MVRAC,
        S_ALU1,
        S_ALU2,
        S_INAC,
        S_CLAC,
        S_NOP,
        S_JPNZ1,
        S_JPNZ2,
        S_END
    } state_e;

    state_e  state_q;
    state_e  state_d;
    alu_op_e alu_sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            done    <= 1'b0;
        end else begin
            state_q <= state_d;
            done    <= (state_q == S_END);     // one cycle after entering end
        end
    end

    // ir still holds the instruction during execute
    always_comb begin
        case (instr.mem.op)
            OP_ADD:  alu_sel = ALU_ADD;
            OP_SUB:  alu_sel = ALU_SUB;
            OP_MULT: alu_sel = ALU_MUL;
            OP_SHL1: alu_sel = ALU_SHL1;
            OP_SHR1: alu_sel = ALU_SHR1;
            default: alu_sel = ALU_PASS;
        endcase
    end

    always_comb begin
        ctrl    = '0;
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                ctrl.pc_clr = 1'b1;
                if (start) state_d = S_FETCH1;
            end
            S_FETCH1: begin
                ctrl.bus_src = BUS_IM;
                ctrl.ld_ir   = 1'b1;
                state_d      = S_FETCH2;
            end
            S_FETCH2: begin
                case (instr.mem.op)
                    OP_LDAC:  state_d = S_LDAC1;
                    OP_STAC:  state_d = S_STAC1;
                    OP_MVACR: state_d = S_MVACR;
                    OP_MVRAC: state_d = S_MVRAC;
                    OP_ADD, OP_SUB, OP_MULT, OP_SHL1, OP_SHR1: state_d = S_ALU1;
                    OP_INAC:  state_d = S_INAC;
                    OP_CLAC:  state_d = S_CLAC;
                    OP_JPNZ:  state_d = S_JPNZ1;
                    OP_ENDOP: state_d = S_END;
                    default:  state_d = S_NOP;      // unknown codes too
                endcase
            end
            S_LDAC1, S_STAC1: begin
                ctrl.bus_src = BUS_IR_ADDR;
                ctrl.ld_ar   = 1'b1;
                state_d      = (state_q == S_LDAC1) ? S_LDAC2 : S_STAC2;
            end
            S_LDAC2: begin
                ctrl.bus_src = BUS_DM;
                ctrl.ld_ac   = 1'b1;
                ctrl.pc_inc  = 1'b1;
                state_d      = S_FETCH1;
            end
            S_STAC2: begin
                ctrl.bus_src = BUS_AC;
                ctrl.ld_dm   = 1'b1;           // ar is valid by now
                ctrl.pc_inc  = 1'b1;
                state_d      = S_FETCH1;
            end
            S_MVACR: begin
                ctrl.bus_src = BUS_AC;
                ctrl.ld_rsel = 1'b1;
                ctrl.pc_inc  = 1'b1;
                state_d      = S_FETCH1;
            end
            S_MVRAC: begin
                ctrl.bus_src = BUS_RSEL;
                ctrl.ld_ac   = 1'b1;
                ctrl.pc_inc  = 1'b1;
                state_d      = S_FETCH1;
            end
            S_ALU1: begin
                ctrl.alu_op = alu_sel;         // operands settle
                state_d     = S_ALU2;
            end
            S_ALU2: begin
                ctrl.alu_op      = alu_sel;
                ctrl.ld_ac       = 1'b1;
                ctrl.ac_from_alu = 1'b1;
                ctrl.pc_inc      = 1'b1;
                state_d          = S_FETCH1;
            end
            S_INAC, S_CLAC, S_NOP: begin
                ctrl.ac_inc = (state_q == S_INAC);
                ctrl.ac_clr = (state_q == S_CLAC);
                ctrl.pc_inc = 1'b1;
                state_d     = S_FETCH1;
            end
            S_JPNZ1: begin
                ctrl.pc_inc = 1'b1;            // overwritten if taken
                state_d     = ac_zero ? S_FETCH1 : S_JPNZ2;
            end
            S_JPNZ2: begin
                ctrl.bus_src = BUS_IR_ADDR;
                ctrl.ld_pc   = 1'b1;
                state_d      = S_FETCH1;
            end
            S_END: state_d = S_END;            // held until reset
            default: state_d = S_IDLE;
        endcase
    end

endmodule

/* rtl/mem_bank.sv */
`timescale 1ns/1ns

module mem_bank
    import isa_pkg::*;
#(
    parameter int DEPTH = 256
) (
    input  logic  clk,
    input  logic  we,
    input  addr_t addr,
    input  data_t wdata,
    output data_t rdata,
    input  logic  host_we,
    input  addr_t host_addr,
    input  data_t host_wdata,
    output data_t host_rdata
);

    data_t mem [DEPTH];

    assign rdata      = mem[addr];             // async read, core side
    assign host_rdata = mem[host_addr];

    always_ff @(posedge clk) begin
        if (host_we) mem[host_addr] <= host_wdata;   // host wins
        else if (we) mem[addr] <= wdata;
    end

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ns

module alu
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  data_t   a,                         // ac
    input  data_t   b,                         // r
    input  alu_op_e op,
    output data_t   y
);

    logic [31:0] prod;

    assign prod = a * b;

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;               // wraps mod 2^16
            ALU_SUB:  y = a - b;
            ALU_MUL:  y = prod[15:0];          // low half only
            ALU_SHL1: y = {a[14:0], 1'b0};
            ALU_SHR1: y = {1'b0, a[15:1]};
            default:  y = a;
        endcase
    end

endmodule

/* rtl/ctrl_pkg.sv */
package ctrl_pkg;

    typedef enum logic [2:0] {
        BUS_NONE    = 3'd0,
        BUS_AC      = 3'd1,
        BUS_RSEL    = 3'd2,                    // register picked by ir rsel
        BUS_IR_ADDR = 3'd3,                    // zero extended address field
        BUS_DM      = 3'd4,
        BUS_IM      = 3'd5
    } bus_src_e;

    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_MUL  = 3'd3,
        ALU_SHL1 = 3'd4,
        ALU_SHR1 = 3'd5
    } alu_op_e;

    typedef struct packed {
        bus_src_e bus_src;
        alu_op_e  alu_op;
        logic     ld_pc;
        logic     ld_ar;
        logic     ld_ir;
        logic     ld_ac;
        logic     ld_rsel;
        logic     ld_dm;                       // dm write strobe
        logic     ac_from_alu;                 // ac takes alu result, not bus
        logic     pc_inc;
        logic     ac_inc;
        logic     ac_clr;
        logic     pc_clr;
    } ctrl_word_t;

    typedef struct packed {
        logic              im_we;
        logic              dm_we;
        isa_pkg::addr_t    addr;
        isa_pkg::data_t    wdata;
    } host_req_t;

endpackage

/* rtl/isa_pkg.sv */
package isa_pkg;

    typedef logic [15:0] data_t;               // machine word
    typedef logic [7:0]  addr_t;               // im and dm address

    // codes follow the state numbers of the older sequencer
    typedef enum logic [5:0] {
        OP_LDAC  = 6'd3,
        OP_STAC  = 6'd8,
        OP_MVACR = 6'd11,                      // ac to r or r1..r4
        OP_MVRAC = 6'd15,                      // r or r1..r4 to ac
        OP_ADD   = 6'd19,
        OP_MULT  = 6'd20,
        OP_SUB   = 6'd22,
        OP_INAC  = 6'd23,
        OP_JPNZ  = 6'd24,
        OP_NOP   = 6'd28,
        OP_CLAC  = 6'd30,
        OP_ENDOP = 6'd31,
        OP_SHL1  = 6'd44,
        OP_SHR1  = 6'd45
    } opcode_e;

    // selects 5 to 7 fall back to r
    typedef enum logic [2:0] {
        REG_R  = 3'd0,
        REG_R1 = 3'd1,
        REG_R2 = 3'd2,
        REG_R3 = 3'd3,
        REG_R4 = 3'd4
    } reg_sel_e;

    typedef struct packed {
        opcode_e    op;                        // [15:10]
        logic [1:0] rsvd;
        addr_t      addr;                      // ldac, stac, jpnz target
    } instr_mem_t;

    typedef struct packed {
        opcode_e    op;
        logic [6:0] rsvd;
        reg_sel_e   rsel;                      // mvacr, mvrac
    } instr_reg_t;

    typedef union packed {
        instr_mem_t mem;
        instr_reg_t rg;
    } instr_u;

endpackage
